// ==== files.f ====
hw/mem_stage_pkg.sv
hw/exe_mem_reg.sv
hw/data_sram.sv
hw/mem_wb_reg.sv
hw/load_align.sv
hw/mem_stage_top.sv
test/mem_stage_checker.sv
test/mem_stage_tb.sv

// ==== hw/data_sram.sv ====
`timescale 1ns/1ps

module data_sram (
    input  logic                                     clk,
    input  logic [mem_stage_pkg::DMEM_ADDR_BITS-1:0] addr,
    input  mem_stage_pkg::word_t                     wdata,
    input  mem_stage_pkg::wmask_t                    wmask,
    output mem_stage_pkg::word_t                     rdata
);
    import mem_stage_pkg::*;

    word_t mem_array [DMEM_WORDS];

    // Read-first port: rdata holds the word as it was before this edge
    always_ff @(posedge clk) begin
        rdata <= mem_array[addr];
        if (wmask != WMASK_NONE) begin
            // A zero mask bit takes the new bit, a one keeps the stored bit
            mem_array[addr] <= (mem_array[addr] & wmask) | (wdata & ~wmask);
        end
    end

endmodule

// ==== hw/exe_mem_reg.sv ====
`timescale 1ns/1ps

module exe_mem_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_stage_pkg::ex_mem_t ex_in,
    output mem_stage_pkg::mem_t    mem
);
    import mem_stage_pkg::*;

    logic       is_store;
    logic [4:0] byte_shift;            // Bit offset of the addressed byte lane
    logic [4:0] half_shift;            // Bit offset of the addressed half lane
    word_t      lane_data;
    wmask_t     lane_mask;

    // Control state, cleared on reset and for bubbles
    logic   valid_q;
    logic   rd_src_q;
    logic   mem_to_reg_q;
    logic   mem_write_q;
    logic   mem_read_q;
    logic   reg_write_q;
    logic   f_reg_write_q;
    wmask_t wmask_q;

    word_t     alu_out_q;
    word_t     r_alu_out_q;
    word_t     pc_q;
    word_t     wdata_q;
    reg_addr_t write_addr_q;
    reg_addr_t f_write_addr_q;
    funct3_t   funct3_q;

    assign is_store   = ex_in.valid && ex_in.mem_write;
    assign byte_shift = {ex_in.alu_out[1:0], 3'b000};
    assign half_shift = {ex_in.alu_out[1], 4'b0000};

    // Move the store into its lanes and clear the mask bits of those lanes
    always_comb begin
        lane_data = ex_in.store_data;
        lane_mask = WMASK_NONE;
        if (is_store) begin
            case (ex_in.funct3)
                F3_BYTE: begin
                    lane_data = word_t'(ex_in.store_data[7:0]) << byte_shift;
                    lane_mask = ~(wmask_t'(8'hff) << byte_shift);
                end
                F3_HALF: begin
                    lane_data = word_t'(ex_in.store_data[15:0]) << half_shift;
                    lane_mask = ~(wmask_t'(16'hffff) << half_shift);
                end
                default: begin
                    lane_mask = '0;    // SW and FSW write the whole word
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q       <= 1'b0;
            rd_src_q      <= 1'b0;
            mem_to_reg_q  <= 1'b0;
            mem_write_q   <= 1'b0;
            mem_read_q    <= 1'b0;
            reg_write_q   <= 1'b0;
            f_reg_write_q <= 1'b0;
            wmask_q       <= WMASK_NONE;
        end else begin
            valid_q       <= ex_in.valid;
            rd_src_q      <= ex_in.valid && ex_in.rd_src;
            mem_to_reg_q  <= ex_in.valid && ex_in.mem_to_reg;
            mem_write_q   <= is_store;
            mem_read_q    <= ex_in.valid && ex_in.mem_read;
            reg_write_q   <= ex_in.valid && ex_in.reg_write;
            f_reg_write_q <= ex_in.valid && ex_in.f_reg_write;
            wmask_q       <= lane_mask;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_q      <= ex_in.alu_out;
        r_alu_out_q    <= ex_in.r_alu_out;
        pc_q           <= ex_in.pc;
        wdata_q        <= lane_data;
        write_addr_q   <= ex_in.write_addr;
        f_write_addr_q <= ex_in.f_write_addr;
        funct3_q       <= ex_in.funct3;
    end

    assign mem = '{valid: valid_q, alu_out: alu_out_q, r_alu_out: r_alu_out_q, pc: pc_q,
                   wdata: wdata_q, wmask: wmask_q, write_addr: write_addr_q,
                   f_write_addr: f_write_addr_q, funct3: funct3_q, rd_src: rd_src_q,
                   mem_to_reg: mem_to_reg_q, mem_write: mem_write_q,
                   mem_read: mem_read_q, reg_write: reg_write_q,
                   f_reg_write: f_reg_write_q};

endmodule

// ==== hw/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  mem_stage_pkg::mem_t  wb_stage,
    input  mem_stage_pkg::word_t rdata,
    output mem_stage_pkg::wb_t   wb_out
);
    import mem_stage_pkg::*;

    logic [4:0] lane_shift;
    word_t      lane_word;             // Addressed lane moved down to bit 0
    word_t      load_ext;
    word_t      pc_plus4;

    assign lane_shift = {wb_stage.alu_out[1:0], 3'b000};
    assign lane_word  = rdata >> lane_shift;
    assign pc_plus4   = wb_stage.pc + 32'd4;

    always_comb begin
        case (wb_stage.funct3)
            F3_BYTE: begin
                load_ext = {{24{lane_word[7]}}, lane_word[7:0]};
            end
            F3_HALF: begin
                load_ext = {{16{lane_word[15]}}, lane_word[15:0]};
            end
            F3_BYTE_U: begin
                load_ext = {24'b0, lane_word[7:0]};
            end
            F3_HALF_U: begin
                load_ext = {16'b0, lane_word[15:0]};
            end
            default: begin
                load_ext = rdata;      // LW and FLW take the whole word
            end
        endcase
    end

    // Integer port: link address first, then load data, then the ALU result
    always_comb begin
        if (wb_stage.rd_src) begin
            wb_out.write_data = pc_plus4;
        end else if (wb_stage.mem_to_reg) begin
            wb_out.write_data = load_ext;
        end else begin
            wb_out.write_data = wb_stage.alu_out;
        end
    end

    // FLW goes to the float file without any lane handling
    assign wb_out.f_write_data = wb_stage.mem_to_reg ? rdata : wb_stage.r_alu_out;

    assign wb_out.reg_write    = wb_stage.valid && wb_stage.reg_write;
    assign wb_out.write_addr   = wb_stage.write_addr;
    assign wb_out.f_reg_write  = wb_stage.valid && wb_stage.f_reg_write;
    assign wb_out.f_write_addr = wb_stage.f_write_addr;

endmodule

// ==== hw/mem_stage_pkg.sv ====
package mem_stage_pkg;

    typedef logic [31:0] word_t;       // Data or byte address
    typedef logic [4:0]  reg_addr_t;   // Register-file index
    typedef logic [2:0]  funct3_t;     // Load/store width code
    typedef logic [31:0] wmask_t;      // Active-low bit write mask

    // Width codes shared by loads and stores
    localparam funct3_t F3_BYTE   = 3'd0;
    localparam funct3_t F3_HALF   = 3'd1;
    localparam funct3_t F3_WORD   = 3'd2;
    localparam funct3_t F3_BYTE_U = 3'd4;
    localparam funct3_t F3_HALF_U = 3'd5;

    // Data memory geometry, indexed by word
    localparam int DMEM_ADDR_BITS = 10;
    localparam int DMEM_WORDS     = 1 << DMEM_ADDR_BITS;

    localparam wmask_t WMASK_NONE = '1;  // No bit is written

    // Item handed over by the execute stage
    typedef struct packed {
        logic      valid;
        word_t     alu_out;       // Integer result, also the memory address
        word_t     r_alu_out;     // Floating-point result
        word_t     pc;
        word_t     store_data;
        reg_addr_t write_addr;
        reg_addr_t f_write_addr;
        funct3_t   funct3;
        logic      rd_src;        // Write pc plus four
        logic      mem_to_reg;
        logic      mem_write;
        logic      mem_read;
        logic      reg_write;
        logic      f_reg_write;
    } ex_mem_t;

    // Item in the memory stage, with the store already placed in its lanes
    typedef struct packed {
        logic      valid;
        word_t     alu_out;
        word_t     r_alu_out;
        word_t     pc;
        word_t     wdata;
        wmask_t    wmask;
        reg_addr_t write_addr;
        reg_addr_t f_write_addr;
        funct3_t   funct3;
        logic      rd_src;
        logic      mem_to_reg;
        logic      mem_write;
        logic      mem_read;
        logic      reg_write;
        logic      f_reg_write;
    } mem_t;

    // Write ports of the integer and floating-point register files
    typedef struct packed {
        logic      reg_write;
        reg_addr_t write_addr;
        word_t     write_data;
        logic      f_reg_write;
        reg_addr_t f_write_addr;
        word_t     f_write_data;
    } wb_t;

endpackage

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                   clk,
    input  logic                   reset,
    input  mem_stage_pkg::ex_mem_t ex_in,
    output mem_stage_pkg::wb_t     wb_out
);
    import mem_stage_pkg::*;

    mem_t  mem;                        // Memory-stage item
    mem_t  wb_stage;                   // Write-back stage item
    word_t rdata;                      // Old word read at the memory edge

    exe_mem_reg u_exe_mem_reg (
        .clk   (clk),
        .reset (reset),
        .ex_in (ex_in),
        .mem   (mem)
    );

    // Word index taken from the byte address
    data_sram u_data_sram (
        .clk   (clk),
        .addr  (mem.alu_out[DMEM_ADDR_BITS+1:2]),
        .wdata (mem.wdata),
        .wmask (mem.wmask),
        .rdata (rdata)
    );

    mem_wb_reg u_mem_wb_reg (
        .clk      (clk),
        .reset    (reset),
        .mem      (mem),
        .wb_stage (wb_stage)
    );

    load_align u_load_align (
        .wb_stage (wb_stage),
        .rdata    (rdata),
        .wb_out   (wb_out)
    );

endmodule

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                clk,
    input  logic                reset,
    input  mem_stage_pkg::mem_t mem,
    output mem_stage_pkg::mem_t wb_stage
);
    import mem_stage_pkg::*;

    logic   valid_q;
    logic   rd_src_q;
    logic   mem_to_reg_q;
    logic   mem_write_q;
    logic   mem_read_q;
    logic   reg_write_q;
    logic   f_reg_write_q;

    word_t     alu_out_q;
    word_t     r_alu_out_q;
    word_t     pc_q;
    reg_addr_t write_addr_q;
    reg_addr_t f_write_addr_q;
    funct3_t   funct3_q;               // Load width, needed beside rdata

    // These registers load on the same edge as the memory output register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q       <= 1'b0;
            rd_src_q      <= 1'b0;
            mem_to_reg_q  <= 1'b0;
            mem_write_q   <= 1'b0;
            mem_read_q    <= 1'b0;
            reg_write_q   <= 1'b0;
            f_reg_write_q <= 1'b0;
        end else begin
            valid_q       <= mem.valid;
            rd_src_q      <= mem.valid && mem.rd_src;
            mem_to_reg_q  <= mem.valid && mem.mem_to_reg;
            mem_write_q   <= mem.valid && mem.mem_write;
            mem_read_q    <= mem.valid && mem.mem_read;
            reg_write_q   <= mem.valid && mem.reg_write;
            f_reg_write_q <= mem.valid && mem.f_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        alu_out_q      <= mem.alu_out;
        r_alu_out_q    <= mem.r_alu_out;
        pc_q           <= mem.pc;
        write_addr_q   <= mem.write_addr;
        f_write_addr_q <= mem.f_write_addr;
        funct3_q       <= mem.funct3;
    end

    // The store is complete once the memory edge has passed, so no store data follows
    assign wb_stage = '{valid: valid_q, alu_out: alu_out_q, r_alu_out: r_alu_out_q,
                        pc: pc_q, wdata: '0, wmask: WMASK_NONE,
                        write_addr: write_addr_q, f_write_addr: f_write_addr_q,
                        funct3: funct3_q, rd_src: rd_src_q, mem_to_reg: mem_to_reg_q,
                        mem_write: mem_write_q, mem_read: mem_read_q,
                        reg_write: reg_write_q, f_reg_write: f_reg_write_q};

endmodule

// ==== test/mem_stage_checker.sv ====
`timescale 1ns/1ps

module mem_stage_checker (
    input logic                clk,
    input logic                reset,
    input mem_stage_pkg::mem_t mem,
    input mem_stage_pkg::wb_t  wb_out
);
    import mem_stage_pkg::*;

    int fail_count = 0;                 // Number of failed assertions so far

    // Whole word, one aligned byte lane or one aligned half lane
    function automatic logic legal_store_mask(wmask_t m);
        logic ok;
        ok = (m == '0);
        for (int k = 0; k < 4; k++) begin
            if (m == ~(wmask_t'(8'hff) << (8 * k))) begin
                ok = 1'b1;
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (m == ~(wmask_t'(16'hffff) << (16 * k))) begin
                ok = 1'b1;
            end
        end
        return ok;
    endfunction

    // Loads, ALU items and bubbles leave the memory alone
    mask_idle_without_store: assert property (@(posedge clk) disable iff (reset)
        !mem.mem_write |-> (mem.wmask == WMASK_NONE))
    else begin
        $error("Write mask is active for an item that is not a store");
        fail_count++;
    end

    store_mask_legal: assert property (@(posedge clk) disable iff (reset)
        mem.mem_write |-> legal_store_mask(mem.wmask))
    else begin
        $error("Store write mask %h is not an aligned byte, half or word", mem.wmask);
        fail_count++;
    end

    // Nothing has reached write-back yet in the first two cycles
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!wb_out.reg_write && !wb_out.f_reg_write)
                         ##1 (!wb_out.reg_write && !wb_out.f_reg_write))
    else begin
        $error("A register write strobe rose right after reset");
        fail_count++;
    end

endmodule

// ==== test/mem_stage_tb.sv ====
`timescale 1ns/1ps

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int FILL_WORDS     = 64;     // Words at the bottom of memory used by the tests
    localparam int DIRECTED_ITEMS = 80;
    localparam int RANDOM_ITEMS   = 1500;
    localparam int ITEM_COUNT     = FILL_WORDS + DIRECTED_ITEMS + RANDOM_ITEMS;

    typedef struct packed {
        logic [31:0] due;                   // Cycle count at which wb_out shows the item
        wb_t         wb;
    } expect_t;

    logic    clk;
    logic    reset;
    ex_mem_t ex_in;
    wb_t     wb_out;

    logic [31:0] lfsr_state  = 32'he94e;
    logic [31:0] cycle_count = '0;
    word_t       shadow [DMEM_WORDS];       // Reference copy of the data memory
    expect_t     expect_q [$];
    expect_t     due_item;

    mem_stage_top DUT (
        .clk    (clk),
        .reset  (reset),
        .ex_in  (ex_in),
        .wb_out (wb_out)
    );

    bind mem_stage_top mem_stage_checker u_checker (
        .clk    (clk),
        .reset  (reset),
        .mem    (mem),
        .wb_out (wb_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
    function automatic word_t rand_bits(int n);
        word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic word_t fill_word(int idx);
        word_t addr;
        addr = word_t'(idx * 4);
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // Expected write-back of one item, with the shadow memory updated in item order
    function automatic wb_t predict(ex_mem_t it);
        wb_t         exp;
        int          idx;
        int          off;
        word_t       old_word;
        word_t       ext;
        logic [7:0]  byte_val;
        logic [15:0] half_val;
        idx      = int'(it.alu_out[DMEM_ADDR_BITS+1:2]);
        off      = int'(it.alu_out[1:0]);
        old_word = shadow[idx];             // The item reads the word before its own write
        byte_val = old_word[8*off +: 8];
        half_val = old_word[16*(off/2) +: 16];
        case (it.funct3)
            F3_BYTE:   ext = {{24{byte_val[7]}}, byte_val};
            F3_HALF:   ext = {{16{half_val[15]}}, half_val};
            F3_BYTE_U: ext = {24'h0, byte_val};
            F3_HALF_U: ext = {16'h0, half_val};
            default:   ext = old_word;
        endcase
        if (it.valid && it.mem_write) begin
            case (it.funct3)
                F3_BYTE: shadow[idx][8*off +: 8] = it.store_data[7:0];
                F3_HALF: shadow[idx][16*(off/2) +: 16] = it.store_data[15:0];
                default: shadow[idx] = it.store_data;
            endcase
        end
        exp.reg_write    = it.valid && it.reg_write;
        exp.write_addr   = it.write_addr;
        exp.write_data   = it.rd_src ? it.pc + 32'd4 : (it.mem_to_reg ? ext : it.alu_out);
        exp.f_reg_write  = it.valid && it.f_reg_write;
        exp.f_write_addr = it.f_write_addr;
        exp.f_write_data = it.mem_to_reg ? old_word : it.r_alu_out;
        return exp;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // A valid item with random data fields and every control bit cleared
    function automatic ex_mem_t base_item();
        ex_mem_t it;
        it              = '0;
        it.valid        = 1'b1;
        it.alu_out      = rand_bits(32);
        it.r_alu_out    = rand_bits(32);
        it.pc           = rand_bits(32) & 32'hffff_fffc;
        it.store_data   = rand_bits(32);
        it.write_addr   = reg_addr_t'(rand_bits(5));
        it.f_write_addr = reg_addr_t'(rand_bits(5));
        return it;
    endfunction

    function automatic word_t aligned_addr(funct3_t f3);
        word_t addr;
        addr = rand_bits(6) << 2;
        case (f3)
            F3_BYTE, F3_BYTE_U: addr = addr | rand_bits(2);
            F3_HALF, F3_HALF_U: addr = addr | (rand_bits(1) << 1);
            default:            addr = addr;
        endcase
        return addr;
    endfunction

    task automatic drive_item(input ex_mem_t it);
        expect_t e;
        @(negedge clk);
        ex_in = it;
        e.due = cycle_count + 2;            // Two edges from ex_in to wb_out
        e.wb  = predict(it);
        expect_q.push_back(e);
    endtask

    task automatic write_mem(input word_t addr, input word_t data, input funct3_t f3);
        ex_mem_t it;
        it            = base_item();
        it.alu_out    = addr;
        it.store_data = data;
        it.funct3     = f3;
        it.mem_write  = 1'b1;
        drive_item(it);
    endtask

    task automatic read_mem(input word_t addr, input funct3_t f3, input logic to_float);
        ex_mem_t it;
        it             = base_item();
        it.alu_out     = addr;
        it.funct3      = f3;
        it.mem_read    = 1'b1;
        it.mem_to_reg  = 1'b1;
        it.reg_write   = !to_float;
        it.f_reg_write = to_float;
        drive_item(it);
    endtask

    task automatic run_alu(input logic link, input logic to_float);
        ex_mem_t it;
        it             = base_item();
        it.rd_src      = link;
        it.reg_write   = !to_float;
        it.f_reg_write = to_float;
        drive_item(it);
    endtask

    // Controls are set so that the cleared valid has something to cancel
    task automatic send_bubble();
        ex_mem_t it;
        it             = base_item();
        it.valid       = 1'b0;
        it.mem_write   = 1'b1;
        it.reg_write   = 1'b1;
        it.f_reg_write = 1'b1;
        drive_item(it);
    endtask

    task automatic random_item();
        logic [2:0] kind;
        funct3_t    f3;
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0: send_bubble();
            3'd1, 3'd2: begin
                f3 = funct3_t'(rand_bits(2) % 3);
                write_mem(aligned_addr(f3), rand_bits(32), f3);
            end
            3'd3, 3'd4: begin
                case (rand_bits(3) % 5)
                    0:       f3 = F3_BYTE;
                    1:       f3 = F3_HALF;
                    2:       f3 = F3_WORD;
                    3:       f3 = F3_BYTE_U;
                    default: f3 = F3_HALF_U;
                endcase
                read_mem(aligned_addr(f3), f3, 1'b0);
            end
            3'd5: read_mem(aligned_addr(F3_WORD), F3_WORD, 1'b1);
            3'd6: run_alu(rand_bits(1) == 1, 1'b0);
            default: run_alu(1'b0, 1'b1);
        endcase
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            assert (DUT.u_checker.fail_count == 0) else begin
                $display("A bound assertion on the DUT failed before %0d ns", $time);
                $display("Test failed");
                $fatal(1);
            end
            if (expect_q.size() != 0 && expect_q[0].due == cycle_count) begin
                due_item = expect_q.pop_front();
                check_value("wb_out.reg_write", word_t'(wb_out.reg_write),
                            word_t'(due_item.wb.reg_write));
                check_value("wb_out.f_reg_write", word_t'(wb_out.f_reg_write),
                            word_t'(due_item.wb.f_reg_write));
                if (due_item.wb.reg_write) begin
                    check_value("wb_out.write_addr", word_t'(wb_out.write_addr),
                                word_t'(due_item.wb.write_addr));
                    check_value("wb_out.write_data", wb_out.write_data, due_item.wb.write_data);
                end
                if (due_item.wb.f_reg_write) begin
                    check_value("wb_out.f_write_addr", word_t'(wb_out.f_write_addr),
                                word_t'(due_item.wb.f_write_addr));
                    check_value("wb_out.f_write_data", wb_out.f_write_data,
                                due_item.wb.f_write_data);
                end
            end else begin
                check_value("wb_out.reg_write", word_t'(wb_out.reg_write), '0);
                check_value("wb_out.f_reg_write", word_t'(wb_out.f_reg_write), '0);
            end
        end
    end

    initial begin
        #((ITEM_COUNT + 200) * 8);
        $display("Timeout: the item stream did not drain in the allowed time");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        reset = 1'b1;
        ex_in = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (4) @(negedge clk);          // Empty pipeline, strobes must stay low
        repeat (4) send_bubble();
        for (int w = 0; w < FILL_WORDS; w++) begin
            write_mem(word_t'(w * 4), fill_word(w), F3_WORD);
        end
        write_mem(32'h40, 32'hdead_beef, F3_WORD);
        read_mem(32'h40, F3_WORD, 1'b0);
        write_mem(32'h44, 32'h3fc0_0000, F3_WORD);  // FSW then FLW
        read_mem(32'h44, F3_WORD, 1'b1);
        for (int lane = 0; lane < 4; lane++) begin
            write_mem(32'h80 + word_t'(lane), rand_bits(32), F3_BYTE);
            read_mem(32'h80, F3_WORD, 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            write_mem(32'h84 + word_t'(2 * half), rand_bits(32), F3_HALF);
            read_mem(32'h84, F3_WORD, 1'b0);
        end
        // Every byte and half of this word has its top bit set
        write_mem(32'hc0, 32'hf08a_80c3, F3_WORD);
        for (int lane = 0; lane < 4; lane++) begin
            read_mem(32'hc0 + word_t'(lane), F3_BYTE, 1'b0);
            read_mem(32'hc0 + word_t'(lane), F3_BYTE_U, 1'b0);
        end
        for (int half = 0; half < 2; half++) begin
            read_mem(32'hc0 + word_t'(2 * half), F3_HALF, 1'b0);
            read_mem(32'hc0 + word_t'(2 * half), F3_HALF_U, 1'b0);
        end
        run_alu(1'b0, 1'b0);
        run_alu(1'b1, 1'b0);
        run_alu(1'b0, 1'b1);
        send_bubble();
        run_alu(1'b1, 1'b0);
        for (int n = 0; n < RANDOM_ITEMS; n++) begin
            random_item();
        end
        repeat (4) send_bubble();
        while (expect_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (DUT.u_checker.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("A bound assertion on the DUT failed");
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule
